// File: verilog/filter_cond_pkg.sv
// Shared widths, FIFO sizes and types for the filter and condition engine
// All compares treat the data word and the operand as unsigned values
// The route fields of the configuration replace only the packet destination
// The sequence id always travels through the engine unchanged
`default_nettype none

package filter_cond_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int DATA_W   = 32;
    localparam int ROUTE_W  = 8;
    localparam int SEQ_ID_W = 8;

    // ------------------------------
    // FIFO and pipeline sizes
    // ------------------------------
    localparam int FIFO_DEPTH  = 16;

    // Output FIFO level that pauses input pops
    // Must stay below FIFO_DEPTH by at least the pipeline depth
    localparam int PROG_THRESH = 8;

    // Cycles from an input pop to the output FIFO write
    localparam int PIPE_STAGES = 3;

    // ------------------------------
    // Compare operations
    // ------------------------------
    typedef enum logic [1:0] {
        CMP_EQ = 2'd0,
        CMP_NE = 2'd1,
        CMP_LT = 2'd2,
        CMP_GT = 2'd3
    } cmp_op_t;

    // ------------------------------
    // Packet and configuration
    // ------------------------------
    typedef struct packed {
        logic [ROUTE_W-1:0]  destination;
        logic [SEQ_ID_W-1:0] seq_id;
    } route_t;

    // Data word in the upper bits, route below it
    typedef struct packed {
        logic [DATA_W-1:0] data;
        route_t            route;
    } engine_packet_t;

    typedef struct packed {
        cmp_op_t            op;
        logic [DATA_W-1:0]  operand;
        // Inverts the raw compare result
        logic               filter_pass;
        // Drop packets that fail the test
        logic               filter_enable;
        // Replace the destination with if_route or else_route
        logic               conditional_flag;
        logic [ROUTE_W-1:0] if_route;
        logic [ROUTE_W-1:0] else_route;
    } filter_config_t;

endpackage : filter_cond_pkg

`default_nettype wire

// File: verilog/packet_fifo.sv
// Synchronous register-array FIFO of engine packets
// Head of the queue is visible on head_packet without a pop (first-word fall-through)
// DEPTH must be 2 or more and ALMOST_FULL_LEVEL must not exceed DEPTH
// A pop on empty and a push on full are ignored
// On a full FIFO a push in the same cycle as a pop is still ignored
`timescale 1ns/10ps
`default_nettype none

module packet_fifo
    import filter_cond_pkg::*;
#(
    parameter int DEPTH             = FIFO_DEPTH,
    parameter int ALMOST_FULL_LEVEL = PROG_THRESH
) (
    input  logic           ap_clk,
    input  logic           areset_generator,
    input  logic           push,
    input  engine_packet_t push_packet,
    input  logic           pop,
    output engine_packet_t head_packet,
    output logic           full,
    output logic           empty,
    output logic           almost_full
);

    // ------------------------------
    // Storage and pointers
    // ------------------------------
    engine_packet_t             mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;

    logic push_ok;
    logic pop_ok;

    assign push_ok = push & ~full;
    assign pop_ok  = pop & ~empty;

    always_ff @(posedge ap_clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_packet;
        end
    end

    // Pointers wrap at DEPTH so any depth works
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // ------------------------------
    // Occupancy
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            count <= '0;
        end else begin
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head_packet = mem[rd_ptr];
    assign full        = (count == DEPTH);
    assign empty       = (count == 0);

    // Raised early so packets already in flight still fit
    assign almost_full = (count >= ALMOST_FULL_LEVEL);

endmodule : packet_fifo

`default_nettype wire

// File: verilog/filter_cond_config_fsm.sv
// Start and configuration handshake for the filter and condition engine
// start is taken in idle, or in busy only while done is high
// cfg_request is a single-cycle pulse, answered by a single-cycle cfg_valid
// cfg_in is sampled on the cfg_valid cycle while waiting for the answer
// A cfg_valid outside the wait state is ignored
`timescale 1ns/10ps
`default_nettype none

module filter_cond_config_fsm
    import filter_cond_pkg::*;
(
    input  logic           ap_clk,
    input  logic           areset_generator,
    input  logic           start,
    input  logic           done,
    output logic           cfg_request,
    input  logic           cfg_valid,
    input  filter_config_t cfg_in,
    output logic           busy,
    output filter_config_t active_config
);

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_REQUEST = 2'd1,
        ST_WAIT    = 2'd2,
        ST_BUSY    = 2'd3
    } cfg_state_t;

    cfg_state_t state;
    cfg_state_t next_state;

    // ------------------------------
    // State register
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    next_state = ST_REQUEST;
                end
            end
            // Request lasts one cycle only
            ST_REQUEST: begin
                next_state = ST_WAIT;
            end
            ST_WAIT: begin
                if (cfg_valid) begin
                    next_state = ST_BUSY;
                end
            end
            ST_BUSY: begin
                // Reconfigure only once drained
                if (start && done) begin
                    next_state = ST_REQUEST;
                end
            end
            default: begin
                next_state = ST_IDLE;
            end
        endcase
    end

    // ------------------------------
    // Outputs
    // ------------------------------
    assign cfg_request = (state == ST_REQUEST);
    assign busy        = (state == ST_BUSY);

    // Active configuration, held until the next capture
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            active_config <= '0;
        end else if ((state == ST_WAIT) && cfg_valid) begin
            active_config <= cfg_in;
        end
    end

endmodule : filter_cond_config_fsm

`default_nettype wire

// File: verilog/filter_cond_pipeline.sv
// Three-stage compare, filter and route pipeline
// Stage 1 compares, stage 2 applies the pass inversion, stage 3 decides and routes
// out_fire and out_packet are registered and feed the output FIFO write port
// A packet accepted on in_fire is written PIPE_STAGES cycles later
// active_config must not change while stage_busy is high
`timescale 1ns/10ps
`default_nettype none

module filter_cond_pipeline
    import filter_cond_pkg::*;
(
    input  logic           ap_clk,
    input  logic           areset_generator,
    input  filter_config_t active_config,
    input  logic           in_fire,
    input  engine_packet_t in_packet,
    output logic           stage_busy,
    output logic           out_fire,
    output engine_packet_t out_packet
);

    // One valid bit per stage, oldest in the top bit
    logic [PIPE_STAGES-1:0] stage_valid;

    logic           cmp_hit;
    logic           s1_hit;
    engine_packet_t s1_packet;
    logic           s2_pass;
    engine_packet_t s2_packet;
    logic           keep;
    logic [ROUTE_W-1:0] cond_route;

    // ------------------------------
    // Stage 1: raw compare
    // ------------------------------
    always_comb begin
        case (active_config.op)
            CMP_EQ:  cmp_hit = (in_packet.data == active_config.operand);
            CMP_NE:  cmp_hit = (in_packet.data != active_config.operand);
            CMP_LT:  cmp_hit = (in_packet.data < active_config.operand);
            default: cmp_hit = (in_packet.data > active_config.operand);
        endcase
    end

    always_ff @(posedge ap_clk) begin
        s1_packet <= in_packet;
        s1_hit    <= cmp_hit;
    end

    // ------------------------------
    // Stage 2: pass bit
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        s2_packet <= s1_packet;
        s2_pass   <= s1_hit ^ active_config.filter_pass;
    end

    // ------------------------------
    // Stage 3: filter and route
    // ------------------------------
    // Filtering off lets every packet through
    assign keep       = s2_pass | ~active_config.filter_enable;
    assign cond_route = s2_pass ? active_config.if_route : active_config.else_route;

    always_ff @(posedge ap_clk) begin
        out_packet.data         <= s2_packet.data;
        out_packet.route.seq_id <= s2_packet.route.seq_id;
        if (active_config.conditional_flag) begin
            out_packet.route.destination <= cond_route;
        end else begin
            out_packet.route.destination <= s2_packet.route.destination;
        end
    end

    // Valid bits and the write strobe
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            stage_valid <= '0;
            out_fire    <= 1'b0;
        end else begin
            stage_valid <= {stage_valid[PIPE_STAGES-2:0], in_fire};
            out_fire    <= stage_valid[PIPE_STAGES-2] & keep;
        end
    end

    // Includes stage 3 even when its packet was dropped
    assign stage_busy = |stage_valid;

endmodule : filter_cond_pipeline

`default_nettype wire

// File: verilog/filter_cond_engine.sv
// Filter and condition engine top level
// Input and output are valid/ready streams, output is first-word fall-through
// Input pops pause while the output FIFO is almost full, so no packet is lost
// done is registered and needs the engine configured and fully drained
// A second start is taken only while done is high
`timescale 1ns/10ps
`default_nettype none

module filter_cond_engine
    import filter_cond_pkg::*;
(
    input  logic           ap_clk,
    input  logic           areset_generator,
    input  logic           start,
    output logic           cfg_request,
    input  filter_config_t cfg_in,
    input  logic           cfg_valid,
    input  engine_packet_t in_packet,
    input  logic           in_valid,
    output logic           in_ready,
    output engine_packet_t out_packet,
    output logic           out_valid,
    input  logic           out_ready,
    output logic           done
);

    filter_config_t active_config;
    engine_packet_t in_head;
    engine_packet_t pipe_packet;

    logic busy;
    logic in_full;
    logic in_empty;
    logic out_empty;
    logic out_almost_full;
    logic pop_in;
    logic pipe_fire;
    logic stage_busy;

    // ------------------------------
    // Configuration
    // ------------------------------
    filter_cond_config_fsm inst_config_fsm (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .start           (start),
        .done            (done),
        .cfg_request     (cfg_request),
        .cfg_valid       (cfg_valid),
        .cfg_in          (cfg_in),
        .busy            (busy),
        .active_config   (active_config)
    );

    // ------------------------------
    // Input FIFO and pipeline
    // ------------------------------
    // The FIFO drops a push on full, so in_valid can drive it directly
    packet_fifo inst_in_fifo (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .push            (in_valid),
        .push_packet     (in_packet),
        .pop             (pop_in),
        .head_packet     (in_head),
        .full            (in_full),
        .empty           (in_empty),
        .almost_full     ()
    );

    assign in_ready = ~in_full;

    // Back-pressure from the output side stops new pops
    assign pop_in = busy & ~in_empty & ~out_almost_full;

    filter_cond_pipeline inst_pipeline (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .active_config   (active_config),
        .in_fire         (pop_in),
        .in_packet       (in_head),
        .stage_busy      (stage_busy),
        .out_fire        (pipe_fire),
        .out_packet      (pipe_packet)
    );

    // ------------------------------
    // Output FIFO
    // ------------------------------
    packet_fifo inst_out_fifo (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .push            (pipe_fire),
        .push_packet     (pipe_packet),
        .pop             (out_ready),
        .head_packet     (out_packet),
        .full            (),
        .empty           (out_empty),
        .almost_full     (out_almost_full)
    );

    assign out_valid = ~out_empty;

    // Configured and nothing left anywhere in the engine
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            done <= 1'b0;
        end else begin
            done <= busy & in_empty & out_empty & ~stage_busy;
        end
    end

endmodule : filter_cond_engine

`default_nettype wire

// File: test/filter_cond_sva.sv
// Handshake assertions for the filter and condition engine top level
// Bound into every filter_cond_engine instance
// All properties are off while reset is high
`timescale 1ns/10ps
`default_nettype none

module filter_cond_sva
    import filter_cond_pkg::*;
(
    input logic           ap_clk,
    input logic           areset_generator,
    input logic           cfg_request,
    input engine_packet_t out_packet,
    input logic           out_valid,
    input logic           out_ready,
    input logic           done
);

    // Single-cycle configuration request
    cfg_request_pulse: assert property (@(posedge ap_clk) disable iff (areset_generator)
        cfg_request |=> !cfg_request)
        else $error("cfg_request held longer than one cycle");

    // Stalled output keeps its head packet
    out_held_stable: assert property (@(posedge ap_clk) disable iff (areset_generator)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_packet)))
        else $error("out_packet changed during an output stall");

    done_not_pending: assert property (@(posedge ap_clk) disable iff (areset_generator)
        !(done && out_valid))
        else $error("done high while out_valid is high");

endmodule : filter_cond_sva

bind filter_cond_engine filter_cond_sva inst_sva (
    .ap_clk          (ap_clk),
    .areset_generator(areset_generator),
    .cfg_request     (cfg_request),
    .out_packet      (out_packet),
    .out_valid       (out_valid),
    .out_ready       (out_ready),
    .done            (done)
);

`default_nettype wire

// File: test/filter_cond_tb.sv
// Testbench for the filter and condition engine
// Inputs change 1 ns after the rising edge, outputs are read at that same point
// Expected packets come from a reference model of the filter and route rules
// Every wait is bounded, a timeout counts as a failure and the run goes on
`timescale 1ns/10ps
`default_nettype none

module filter_cond_tb
    import filter_cond_pkg::*;
();

    localparam int SEND_TIMEOUT  = 1000;
    localparam int DRAIN_TIMEOUT = 3000;

    logic           ap_clk = 1'b0;
    logic           areset_generator;
    logic           start;
    logic           cfg_request;
    filter_config_t cfg_in;
    logic           cfg_valid;
    engine_packet_t in_packet;
    logic           in_valid;
    logic           in_ready;
    engine_packet_t out_packet;
    logic           out_valid;
    logic           out_ready;
    logic           done;

    filter_config_t cur_cfg;
    engine_packet_t exp_q[$];
    int             value_errors = 0;
    int             other_errors = 0;
    int             ready_pct = 100;
    logic           hold_output = 1'b0;
    logic           saw_in_ready_low = 1'b0;

    always #5 ap_clk = ~ap_clk;

    filter_cond_engine uut (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .start           (start),
        .cfg_request     (cfg_request),
        .cfg_in          (cfg_in),
        .cfg_valid       (cfg_valid),
        .in_packet       (in_packet),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .out_packet      (out_packet),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .done            (done)
    );

    // ------------------------------
    // Reference model and helpers
    // ------------------------------
    // Returns the keep flag, the expected packet goes out through exp_pkt
    function automatic logic expected_packet(input engine_packet_t pkt,
                                             input filter_config_t cfg,
                                             output engine_packet_t exp_pkt);
        logic hit;
        logic pass;
        case (cfg.op)
            CMP_EQ:  hit = (pkt.data == cfg.operand);
            CMP_NE:  hit = (pkt.data != cfg.operand);
            CMP_LT:  hit = (pkt.data < cfg.operand);
            default: hit = (pkt.data > cfg.operand);
        endcase
        pass = cfg.filter_pass ? ~hit : hit;
        exp_pkt = pkt;
        if (cfg.conditional_flag) begin
            exp_pkt.route.destination = pass ? cfg.if_route : cfg.else_route;
        end
        return pass | ~cfg.filter_enable;
    endfunction

    function automatic filter_config_t make_config(input cmp_op_t op, input logic fp,
                                                   input logic fe, input logic cond);
        filter_config_t cfg;
        cfg.op               = op;
        cfg.operand          = $urandom;
        cfg.filter_pass      = fp;
        cfg.filter_enable    = fe;
        cfg.conditional_flag = cond;
        cfg.if_route         = 8'($urandom);
        cfg.else_route       = 8'($urandom);
        return cfg;
    endfunction

    // A quarter of the words hit the operand exactly
    function automatic engine_packet_t random_packet(input logic [DATA_W-1:0] operand);
        engine_packet_t pkt;
        pkt.data              = (($urandom % 4) == 0) ? operand : $urandom;
        pkt.route.destination = 8'($urandom);
        pkt.route.seq_id      = 8'($urandom);
        return pkt;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
            value_errors++;
        end
    endtask

    // ------------------------------
    // Stimulus tasks
    // ------------------------------
    task automatic configure(input filter_config_t cfg);
        start = 1'b1;
        @(posedge ap_clk);
        #1;
        start = 1'b0;
        check_value("cfg_request", 64'(cfg_request), 64'd1);
        // Answer once the FSM has moved on to wait for it
        @(posedge ap_clk);
        #1;
        check_value("cfg_request", 64'(cfg_request), 64'd0);
        cfg_in    = cfg;
        cfg_valid = 1'b1;
        @(posedge ap_clk);
        #1;
        cfg_valid = 1'b0;
        cur_cfg = cfg;
    endtask

    task automatic send_packet(input engine_packet_t pkt);
        engine_packet_t exp_pkt;
        logic           keep;
        int             waited;
        keep      = expected_packet(pkt, cur_cfg, exp_pkt);
        in_packet = pkt;
        in_valid  = 1'b1;
        waited    = 0;
        while (!in_ready && waited < SEND_TIMEOUT) begin
            saw_in_ready_low = 1'b1;
            @(posedge ap_clk);
            #1;
            waited++;
        end
        if (!in_ready) begin
            $display("Timeout: input stream never became ready at %0t", $time);
            other_errors++;
        end else begin
            if (keep) begin
                exp_q.push_back(exp_pkt);
            end
            @(posedge ap_clk);
            #1;
        end
        in_valid = 1'b0;
    endtask

    task automatic send_random(input int count);
        for (int i = 0; i < count; i++) begin
            send_packet(random_packet(cur_cfg.operand));
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (!(exp_q.size() == 0 && done) && waited < DRAIN_TIMEOUT) begin
            @(posedge ap_clk);
            #1;
            waited++;
        end
        if (exp_q.size() != 0 || !done) begin
            $display("Timeout: engine did not drain, %0d packets still expected",
                     exp_q.size());
            other_errors++;
        end
    endtask

    // ------------------------------
    // Output side and compare
    // ------------------------------
    initial begin
        logic           stalled;
        engine_packet_t held;
        stalled = 1'b0;
        held    = '0;
        forever begin
            @(posedge ap_clk);
            #1;
            if (areset_generator) begin
                out_ready = 1'b0;
            end else begin
                out_ready = !hold_output && (($urandom % 100) < ready_pct);
                if (stalled) begin
                    check_value("out_packet", 64'(out_packet), 64'(held));
                end
                if (done && out_valid) begin
                    $display("Error: done is high while output is pending at %0t", $time);
                    other_errors++;
                end
                if (out_valid && out_ready) begin
                    if (exp_q.size() == 0) begin
                        $display("Error: unexpected output packet 0x%0h", out_packet);
                        other_errors++;
                    end else begin
                        check_value("out_packet", 64'(out_packet), 64'(exp_q.pop_front()));
                    end
                end
                stalled = out_valid && !out_ready;
                held    = out_packet;
            end
        end
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        filter_config_t first_cfg;
        engine_packet_t early_pkt;
        engine_packet_t early_exp;
        logic           early_keep;
        void'($urandom(32'h53f6_041b));
        areset_generator = 1'b1;
        start     = 1'b0;
        cfg_in    = '0;
        cfg_valid = 1'b0;
        in_packet = '0;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        cur_cfg   = '0;
        repeat (16) @(posedge ap_clk);
        #1;
        areset_generator = 1'b0;
        check_value("cfg_request", 64'(cfg_request), 64'd0);
        check_value("out_valid", 64'(out_valid), 64'd0);
        check_value("done", 64'(done), 64'd0);
        check_value("in_ready", 64'(in_ready), 64'd1);

        // A packet waiting before configuration must stay in the input FIFO
        first_cfg = make_config(CMP_EQ, 1'b0, 1'b1, 1'b0);
        early_pkt = random_packet(first_cfg.operand);
        in_packet = early_pkt;
        in_valid  = 1'b1;
        @(posedge ap_clk);
        #1;
        in_valid = 1'b0;
        repeat (5) @(posedge ap_clk);
        #1;
        check_value("out_valid", 64'(out_valid), 64'd0);

        // Filtering for each compare and both pass settings
        ready_pct = 80;
        configure(first_cfg);
        early_keep = expected_packet(early_pkt, cur_cfg, early_exp);
        if (early_keep) begin
            exp_q.push_back(early_exp);
        end
        for (int i = 0; i < 8; i++) begin
            if (i > 0) begin
                wait_drained();
                configure(make_config(cmp_op_t'(i / 2), 1'(i % 2), 1'b1, 1'b0));
            end
            send_random(100);
        end

        // Conditional routing with every packet kept
        wait_drained();
        configure(make_config(CMP_LT, 1'b0, 1'b0, 1'b1));
        send_random(100);

        // Random and long output stalls
        wait_drained();
        configure(make_config(CMP_GT, 1'b1, 1'b0, 1'b1));
        ready_pct = 50;
        saw_in_ready_low = 1'b0;
        fork
            send_random(60);
            begin
                hold_output = 1'b1;
                repeat (200) @(posedge ap_clk);
                #1;
                hold_output = 1'b0;
            end
        join
        if (!saw_in_ready_low) begin
            $display("Error: input ready never fell during the output stall");
            other_errors++;
        end

        // Drain, then reconfigure with new rules
        wait_drained();
        ready_pct = 90;
        configure(make_config(CMP_NE, 1'b0, 1'b1, 1'b1));
        send_random(50);
        wait_drained();

        $display("Checks done: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule : filter_cond_tb

`default_nettype wire

// File: sim.f
verilog/filter_cond_pkg.sv
verilog/packet_fifo.sv
verilog/filter_cond_config_fsm.sv
verilog/filter_cond_pipeline.sv
verilog/filter_cond_engine.sv
test/filter_cond_sva.sv
test/filter_cond_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the filter and condition engine testbench with Verilator.
# The run passes only if the log holds the pass message.
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module filter_cond_tb \
    -f sim.f \
    -o Vfilter_cond_tb

./obj_dir/Vfilter_cond_tb > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Result: PASSED" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi
